/* logic/eeprom_pkg.sv */
package eeprom_pkg;

    // host address, 2 Kbyte part
    localparam int addr_w = 11;

    // upper nibble of every select byte
    localparam logic [3:0] dev_type_code = 4'b1010;

    typedef enum logic [1:0] {
        op_start,
        op_stop,
        op_write_byte,
        op_read_byte
    } bit_op_e;

    // one command to the bit engine, go is a single-cycle strobe
    typedef struct packed {
        logic       go;
        bit_op_e    op;
        logic [7:0] wr_byte;
        logic       last;      // nack after a read byte
    } bit_cmd_t;

    typedef struct packed {
        logic       done;
        logic       slave_ack; // ack bit seen low
        logic [7:0] rd_byte;
    } bit_rsp_t;

    typedef struct packed {
        logic [3:0] dev_type;
        logic [2:0] block;     // addr[10:8]
        logic       rw;        // 1 = read
    } dev_select_t;

    // select byte, built by fields, shifted as raw
    typedef union packed {
        dev_select_t fields;
        logic [7:0]  raw;
    } dev_select_u;

endpackage

/* logic/eeprom_bit_engine.sv */
`timescale 1ns/1ps

module eeprom_bit_engine import eeprom_pkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  bit_cmd_t cmd,
    input  logic     sda_in,
    output bit_rsp_t rsp,
    output logic     scl,
    output logic     sda_out,
    output logic     sda_oe
);

    logic       busy;
    logic       started;   // first low-phase step taken
    logic [3:0] bit_cnt;   // 0..7 data, 8 = ack slot
    logic       done_q;

    bit_op_e    op_q;
    logic       last_q;
    logic [7:0] tx_sh;
    logic [7:0] rx_sh;
    logic       ack_q;

    bit_op_e    op_cur;
    logic       last_cur;
    logic [7:0] tx_cur;
    logic       low_step;
    logic       high_step;
    logic       ack_bit;
    logic       finish;

    // a go seen while scl is low starts the first step at once
    assign op_cur    = busy ? op_q : cmd.op;
    assign last_cur  = busy ? last_q : cmd.last;
    assign tx_cur    = busy ? tx_sh : cmd.wr_byte;
    assign low_step  = (busy | cmd.go) & ~scl;
    assign high_step = busy & started & scl;
    assign ack_bit   = (bit_cnt == 4'd8);

    always_comb begin
        finish = 1'b0;
        if (high_step) begin
            case (op_q)
                op_start, op_stop: finish = 1'b1;
                default:           finish = ack_bit;
            endcase
        end
    end

    assign rsp = '{done: done_q, slave_ack: ack_q, rd_byte: rx_sh};

    // bus clock is CLK/2, toggled on the falling edge so sda moves mid-phase
    always_ff @(negedge CLK) begin
        if (RESET)
            scl <= 1'b0;
        else
            scl <= ~scl;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy    <= 1'b0;
            started <= 1'b0;
            bit_cnt <= 4'd0;
            done_q  <= 1'b0;
            sda_out <= 1'b1;
            sda_oe  <= 1'b0;
        end else begin
            done_q <= finish;
            if (cmd.go && !busy) begin
                busy    <= 1'b1;
                started <= 1'b0;
            end
            if (low_step) begin
                started <= 1'b1;
                case (op_cur)
                    op_start: begin
                        sda_out <= 1'b1;
                        sda_oe  <= 1'b1;
                    end
                    op_stop: begin
                        sda_out <= 1'b0;
                        sda_oe  <= 1'b1;
                    end
                    op_write_byte: begin
                        if (ack_bit) begin
                            sda_oe <= 1'b0;        // let the slave answer
                        end else begin
                            sda_out <= tx_cur[7];
                            sda_oe  <= 1'b1;
                        end
                    end
                    default: begin
                        if (ack_bit) begin
                            sda_out <= last_cur;   // 1 = nack
                            sda_oe  <= 1'b1;
                        end else begin
                            sda_oe <= 1'b0;
                        end
                    end
                endcase
            end else if (high_step) begin
                case (op_q)
                    op_start: sda_out <= 1'b0;     // start, sda falls with scl high
                    op_stop: begin
                        sda_out <= 1'b1;
                        sda_oe  <= 1'b0;           // pull-up takes it high
                    end
                    default: begin
                        if (!ack_bit)
                            bit_cnt <= bit_cnt + 4'd1;
                    end
                endcase
                if (finish) begin
                    busy    <= 1'b0;
                    started <= 1'b0;
                    bit_cnt <= 4'd0;
                end
            end
        end
    end

    // shift registers and latched command
    always_ff @(posedge CLK) begin
        if (cmd.go && !busy) begin
            op_q   <= cmd.op;
            last_q <= cmd.last;
            tx_sh  <= cmd.wr_byte;
        end
        if (low_step && op_cur == op_write_byte && !ack_bit)
            tx_sh <= {tx_cur[6:0], 1'b0};  // msb first
        if (high_step && op_q == op_read_byte && !ack_bit)
            rx_sh <= {rx_sh[6:0], sda_in};
        if (high_step && op_q == op_write_byte && ack_bit)
            ack_q <= ~sda_in;
    end

endmodule

/* logic/eeprom_wr_ctrl.sv */
`timescale 1ns/1ps

module eeprom_wr_ctrl import eeprom_pkg::*; #(
    parameter logic [3:0] dev_type = dev_type_code
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [addr_w-1:0] addr,
    input  logic [7:0]        data_in,
    input  bit_rsp_t          rsp,
    output bit_cmd_t          cmd,
    output logic [7:0]        data_out,
    output logic              data_oe,
    output logic              ack,
    output logic              nack
);

    localparam logic [9:0] st_idle    = 10'b00_0000_0001;
    localparam logic [9:0] st_start   = 10'b00_0000_0010;
    localparam logic [9:0] st_sel_wr  = 10'b00_0000_0100;
    localparam logic [9:0] st_addr    = 10'b00_0000_1000;
    localparam logic [9:0] st_data_wr = 10'b00_0001_0000;
    localparam logic [9:0] st_restart = 10'b00_0010_0000;
    localparam logic [9:0] st_sel_rd  = 10'b00_0100_0000;
    localparam logic [9:0] st_read    = 10'b00_1000_0000;
    localparam logic [9:0] st_stop    = 10'b01_0000_0000;
    localparam logic [9:0] st_done    = 10'b10_0000_0000;

    logic [9:0]        state;
    logic [9:0]        next_state;
    logic              cmd_go;
    logic              err;       // some slave ack was missing

    logic [addr_w-1:0] addr_q;
    logic [7:0]        wdata_q;
    logic              is_rd;
    logic [7:0]        rd_q;

    dev_select_u       sel;
    bit_op_e           nxt_op;
    logic [7:0]        nxt_byte;
    logic              nxt_last;
    logic              byte_out_st;
    logic              stop_done;

    // go in the done cycle, so the next bit follows without an idle scl pulse
    assign cmd_go      = (next_state != state) && (next_state != st_done) &&
                         (next_state != st_idle);
    assign cmd         = '{go: cmd_go, op: nxt_op, wr_byte: nxt_byte, last: nxt_last};
    assign data_out    = rd_q;
    assign stop_done   = (state == st_stop) && rsp.done;
    assign byte_out_st = (state == st_sel_wr) || (state == st_addr) ||
                         (state == st_data_wr) || (state == st_sel_rd);

    always_comb begin
        next_state = state;
        case (state)
            st_idle:    if (wr || rd) next_state = st_start;
            st_start:   if (rsp.done) next_state = st_sel_wr;
            st_sel_wr:  if (rsp.done) next_state = rsp.slave_ack ? st_addr : st_stop;
            st_addr: begin
                if (rsp.done) begin
                    if (!rsp.slave_ack)
                        next_state = st_stop;      // skip the rest
                    else
                        next_state = is_rd ? st_restart : st_data_wr;
                end
            end
            st_data_wr: if (rsp.done) next_state = st_stop;
            st_restart: if (rsp.done) next_state = st_sel_rd;
            st_sel_rd:  if (rsp.done) next_state = rsp.slave_ack ? st_read : st_stop;
            st_read:    if (rsp.done) next_state = st_stop;
            st_stop:    if (rsp.done) next_state = st_done;
            st_done:    if (!wr && !rd) next_state = st_idle;
            default:    next_state = st_idle;
        endcase
    end

    // command for the state being entered
    always_comb begin
        sel.fields.dev_type = dev_type;
        sel.fields.block    = addr_q[addr_w-1:8];
        sel.fields.rw       = (next_state == st_sel_rd);
        nxt_op   = op_start;
        nxt_byte = 8'h00;
        nxt_last = 1'b0;
        case (next_state)
            st_sel_wr, st_sel_rd: begin
                nxt_op   = op_write_byte;
                nxt_byte = sel.raw;
            end
            st_addr: begin
                nxt_op   = op_write_byte;
                nxt_byte = addr_q[7:0];
            end
            st_data_wr: begin
                nxt_op   = op_write_byte;
                nxt_byte = wdata_q;
            end
            st_read: begin
                nxt_op   = op_read_byte;
                nxt_last = 1'b1;                  // single byte, nack it
            end
            st_stop: nxt_op = op_stop;
            default: nxt_op = op_start;           // start and restart
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= st_idle;
            err     <= 1'b0;
            ack     <= 1'b0;
            nack    <= 1'b0;
            data_oe <= 1'b0;
        end else begin
            state <= next_state;
            ack   <= stop_done;
            nack  <= stop_done && err;
            if (state == st_idle)
                err <= 1'b0;
            else if (byte_out_st && rsp.done && !rsp.slave_ack)
                err <= 1'b1;
            if (stop_done && is_rd)
                data_oe <= 1'b1;
            else if (!rd)
                data_oe <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == st_idle && (wr || rd)) begin
            addr_q <= addr;
            is_rd  <= !wr;                        // wr wins
            if (wr)
                wdata_q <= data_in;
        end
        if (state == st_read && rsp.done)
            rd_q <= rsp.rd_byte;
    end

endmodule

/* logic/eeprom_host.sv */
`timescale 1ns/1ps

module eeprom_host import eeprom_pkg::*; #(
    parameter logic [3:0] dev_type = dev_type_code
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [addr_w-1:0] addr,
    inout  wire  [7:0]        data,
    output logic              ack,
    output logic              nack,
    output logic              scl,
    inout  wire               sda
);

    bit_cmd_t   cmd;
    bit_rsp_t   rsp;
    logic       sda_out;
    logic       sda_oe;
    logic [7:0] data_out;
    logic       data_oe;

    // open bus when not driving, pull-up is external
    assign sda  = sda_oe ? sda_out : 1'bz;
    assign data = (data_oe && !wr) ? data_out : 8'hzz;

    eeprom_wr_ctrl #(
        .dev_type (dev_type)
    ) u_ctrl (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .data_in  (data),
        .rsp      (rsp),
        .cmd      (cmd),
        .data_out (data_out),
        .data_oe  (data_oe),
        .ack      (ack),
        .nack     (nack)
    );

    eeprom_bit_engine u_bits (
        .CLK     (CLK),
        .RESET   (RESET),
        .cmd     (cmd),
        .sda_in  (sda),
        .rsp     (rsp),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe)
    );

endmodule

/* verification/eeprom_model.sv */
`timescale 1ns/1ps

module eeprom_model import eeprom_pkg::*; (
    input  logic scl,
    inout  wire  sda,
    input  logic ack_en    // 0 = never acknowledge
);

    logic [7:0]  mem [0:2047];
    int          phase = 0;      // 0 idle, 1 select, 2 word addr, 3 data, 4 send
    int          next_phase = 0;
    int          bit_i = 0;
    logic [7:0]  sh = 8'h00;
    logic [7:0]  tx = 8'hff;
    logic [2:0]  blk = 3'd0;
    logic [7:0]  word_a = 8'h00;
    logic        ack_on = 1'b0;
    logic        drive_low = 1'b0;
    dev_select_u sel;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff;         // erased part
    end

    task automatic decode_byte();
        ack_on     = ack_en;
        next_phase = 0;
        case (phase)
            1: begin
                sel.raw = sh;
                if (sel.fields.dev_type != dev_type_code) begin
                    ack_on = 1'b0;
                end else if (sel.fields.rw) begin
                    tx         = mem[{sel.fields.block, word_a}];
                    next_phase = 4;
                end else begin
                    blk        = sel.fields.block;
                    next_phase = 2;
                end
            end
            2: begin
                word_a     = sh;
                next_phase = 3;
            end
            default: begin
                if (ack_en)
                    mem[{blk, word_a}] = sh;  // write completes at once
            end
        endcase
        if (!ack_on)
            next_phase = 0;
    endtask

    // start and repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            phase     = 1;
            bit_i     = 0;
            drive_low = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1)
            phase = 0;               // stop
    end

    always @(posedge scl) begin
        if (phase == 4) begin
            if (bit_i < 8) begin
                bit_i++;
            end else begin
                bit_i = 0;
                phase = 0;           // master nack, wait for stop
            end
        end else if (phase != 0) begin
            if (bit_i < 8) begin
                sh = {sh[6:0], sda};
                bit_i++;
                if (bit_i == 8)
                    decode_byte();
            end else begin
                bit_i = 0;
                phase = next_phase;
            end
        end
    end

    // release at once, drive low after the host has let go
    always @(negedge scl) begin
        logic want;
        drive_low = 1'b0;
        want = 1'b0;
        if (phase == 4 && bit_i < 8)
            want = !tx[3'(7 - bit_i)];
        else if (phase >= 1 && phase <= 3 && bit_i == 8 && ack_on)
            want = 1'b1;
        if (want) begin
            #25;
            drive_low = 1'b1;
        end
    end

endmodule

/* verification/eeprom_host_chk.sv */
`timescale 1ns/1ps

module eeprom_host_chk import eeprom_pkg::*; (
    input logic    CLK,
    input logic    RESET,
    input logic    scl,
    input logic    sda,
    input logic    ack,
    input logic    rd,
    input logic    wr,
    input logic    data_oe,
    input bit_op_e bit_op
);

    // scl sampled here is the level of the half period just ended
    sda_stable_in_high: assert property (@(negedge CLK) disable iff (RESET)
        scl |-> ($stable(sda) || bit_op == op_start || bit_op == op_stop))
        else $error("sda moved while scl was high");

    ack_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack)
        else $error("ack high for two cycles");

    no_data_without_rd: assert property (@(posedge CLK) disable iff (RESET)
        (!rd && !$past(rd)) |-> !(data_oe && !wr))
        else $error("data bus driven while rd low");

endmodule

bind eeprom_host eeprom_host_chk u_chk (
    .CLK     (CLK),
    .RESET   (RESET),
    .scl     (scl),
    .sda     (sda),
    .ack     (ack),
    .rd      (rd),
    .wr      (wr),
    .data_oe (data_oe),
    .bit_op  (u_bits.op_q)
);

/* verification/eeprom_host_tb.sv */
`timescale 1ns/1ps

module eeprom_host_tb import eeprom_pkg::*;;

    logic        CLK = 1'b0;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic        mem_ack_en;
    wire  [7:0]  data;
    wire         ack;
    wire         nack;
    wire         scl;
    wire         sda;

    logic [7:0]  ref_mem [0:2047];
    int          errors = 0;
    int          tests = 0;
    int          seed = 27281;

    pullup (sda);
    assign data = wr ? wdata : 8'hzz;

    eeprom_host dut (
        .CLK (CLK), .RESET (RESET), .wr (wr), .rd (rd), .addr (addr),
        .data (data), .ack (ack), .nack (nack), .scl (scl), .sda (sda)
    );

    eeprom_model u_mem (.scl (scl), .sda (sda), .ack_en (mem_ack_en));

    always #20 CLK = ~CLK;

    // returns at the falling edge of the ack cycle
    task automatic wait_ack(output logic got, output logic nk, output logic [7:0] rb);
        got = 1'b0;
        nk  = 1'b0;
        rb  = 8'h00;
        for (int n = 0; n < 500 && !got; n++) begin
            @(negedge CLK);
            if (ack) begin
                got = 1'b1;
                nk  = nack;
                rb  = data;
            end
        end
        assert (got) else begin
            $display("timeout: no ack within 500 cycles");
            errors++;
        end
    endtask

    task automatic do_write(input logic [10:0] a, input logic [7:0] d, output logic nk);
        logic       got;
        logic [7:0] rb;
        @(negedge CLK);
        addr  = a;
        wdata = d;
        wr    = 1'b1;
        wait_ack(got, nk, rb);
        wr = 1'b0;
        @(negedge CLK);
    endtask

    task automatic check_read(input logic [10:0] a, input logic [7:0] exp);
        logic       got;
        logic       nk;
        logic [7:0] rb;
        @(negedge CLK);
        addr = a;
        rd   = 1'b1;
        wait_ack(got, nk, rb);
        rd = 1'b0;
        assert (!got || rb == exp) else begin
            $display("Error: data at %h = %h, expected %h", a, rb, exp);
            errors++;
        end
        assert (!got || !nk) else begin
            $display("Error: nack = %h, expected %h", nk, 1'b0);
            errors++;
        end
        @(negedge CLK);
    endtask

    task automatic write_ok(input logic [10:0] a, input logic [7:0] d);
        logic nk;
        do_write(a, d, nk);
        assert (!nk) else begin
            $display("Error: nack = %h, expected %h", nk, 1'b0);
            errors++;
        end
        ref_mem[a] = d;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    task automatic test_idle();
        int e0 = errors;
        for (int i = 0; i < 20; i++) begin
            @(negedge CLK);
            assert (sda === 1'b1 && !ack && !nack) else begin
                $display("Error: sda = %h, ack = %h, nack = %h", sda, ack, nack);
                errors++;
            end
        end
        finish_test("idle after reset", e0);
    endtask

    task automatic test_single();
        int e0 = errors;
        write_ok(11'h123, 8'ha5);
        check_read(11'h123, 8'ha5);
        finish_test("single write and read", e0);
    endtask

    task automatic test_random();
        int          e0 = errors;
        logic [10:0] a [32];
        logic [7:0]  lo;
        for (int i = 0; i < 32; i++) begin
            if (i % 8 == 0)
                lo = 8'($random(seed));   // same low byte in all eight blocks
            a[i] = {3'(i % 8), lo};
            write_ok(a[i], 8'($random(seed)));
        end
        for (int i = 0; i < 32; i++)
            check_read(a[i], ref_mem[a[i]]);
        finish_test("random blocks", e0);
    endtask

    task automatic test_unwritten();
        int e0 = errors;
        check_read(11'h7fe, ref_mem[11'h7fe]);
        assert (ref_mem[11'h7fe] == 8'hff) else begin
            $display("address 7fe was written before this test");
            errors++;
        end
        finish_test("unwritten address", e0);
    endtask

    task automatic test_no_ack();
        int   e0 = errors;
        logic nk;
        mem_ack_en = 1'b0;
        do_write(11'h123, 8'h3c, nk);
        assert (nk) else begin
            $display("Error: nack = %h, expected %h", nk, 1'b1);
            errors++;
        end
        mem_ack_en = 1'b1;
        check_read(11'h123, ref_mem[11'h123]);
        finish_test("missing acknowledge", e0);
    endtask

    initial begin
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = 8'hff;
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = 8'h00;
        mem_ack_en = 1'b1;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        test_idle();
        test_single();
        test_random();
        test_unwritten();
        test_no_ack();

        $display("summary: %0d tests, %0d errors", tests, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* eeprom_host.f */
logic/eeprom_pkg.sv
logic/eeprom_bit_engine.sv
logic/eeprom_wr_ctrl.sv
logic/eeprom_host.sv
verification/eeprom_model.sv
verification/eeprom_host_chk.sv
verification/eeprom_host_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= eeprom_host_tb
FILELIST  ?= eeprom_host.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
